//--- Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -j 0 --top-module ex_stage_tb -Mdir obj_dir -f sources.f
	./obj_dir/Vex_stage_tb

clean:
	rm -rf obj_dir

//--- hw/ex_agu.sv
module ex_agu (
    input  ex_pkg::alu_op_e         op_i,
    input  logic [ex_pkg::XLEN-1:0] src1_i,
    input  logic [ex_pkg::XLEN-1:0] src2_i,
    input  logic [ex_pkg::XLEN-1:0] imm_i,
    output logic [ex_pkg::XLEN-1:0] addr_o,
    output logic [3:0]              be_o,
    output logic [ex_pkg::XLEN-1:0] wdata_o,
    output logic                    we_o,
    output logic                    align_err_o
);

    logic                    is_mem;
    logic                    is_store;
    lsu_pkg::mem_size_e      size;
    logic [ex_pkg::XLEN-1:0] addr;
    logic [4:0]              lane_sh;

    assign is_mem   = (ex_pkg::class_of(op_i) == ex_pkg::CLS_MEM);
    assign is_store = (op_i == ex_pkg::STB) || (op_i == ex_pkg::STH)
                      || (op_i == ex_pkg::STW);
    assign size     = lsu_pkg::size_of(op_i);

    // loads are register indexed, stores use the immediate
    assign addr     = is_store ? (src1_i + imm_i) : (src1_i + src2_i);
    assign lane_sh  = {addr[1:0], 3'b000};

    always_comb begin
        addr_o      = '0;
        be_o        = '0;
        wdata_o     = '0;
        we_o        = 1'b0;
        align_err_o = 1'b0;
        if (is_mem) begin
            addr_o = addr;
            we_o   = is_store;
            case (size)
                lsu_pkg::SZ_BYTE: begin
                    be_o = 4'b0001 << addr[1:0];
                    if (is_store) begin
                        wdata_o = {24'b0, src2_i[7:0]} << lane_sh;
                    end
                end
                lsu_pkg::SZ_HALF: begin
                    align_err_o = addr[0];
                    if (!addr[0]) begin
                        be_o = addr[1] ? 4'b1100 : 4'b0011;
                    end
                    if (is_store) begin
                        wdata_o = {16'b0, src2_i[15:0]} << {addr[1], 4'b0000};
                    end
                end
                default: begin
                    align_err_o = (addr[1:0] != 2'b00);
                    be_o        = align_err_o ? 4'b0000 : 4'b1111;
                    if (is_store) begin
                        wdata_o = src2_i;
                    end
                end
            endcase
        end
    end

endmodule

//--- hw/ex_arith.sv
module ex_arith #(
    parameter int MUL_STAGES = 2
) (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    flush_i,
    input  logic                    valid_i,
    input  ex_pkg::alu_op_e         op_i,
    input  logic [ex_pkg::XLEN-1:0] src1_i,
    input  logic [ex_pkg::XLEN-1:0] src2_i,
    output logic [ex_pkg::XLEN-1:0] result_o,
    output logic                    busy_o
);

    ex_pkg::op_class_e       cls;
    logic                    is_mul;
    logic                    is_div;
    logic                    issue;
    logic                    start_mul_q;
    logic                    start_div_q;
    logic                    mul_pend_q;
    logic                    sgn_q;
    logic [ex_pkg::XLEN-1:0] op_a_q;
    logic [ex_pkg::XLEN-1:0] op_b_q;
    logic [ex_pkg::XLEN-1:0] alu_res;
    logic [4:0]              shamt;
    logic                    mul_done;
    logic [63:0]             product;
    logic                    div_busy;
    logic                    div_done;
    logic [31:0]             quotient;
    logic [31:0]             remainder;

    assign cls    = ex_pkg::class_of(op_i);
    assign is_mul = valid_i && (cls == ex_pkg::CLS_MUL);
    assign is_div = valid_i && (cls == ex_pkg::CLS_DIV);
    assign shamt  = src2_i[4:0];

    // one start per op, never while a unit is still working or reporting
    assign issue = (is_mul || is_div) && !flush_i && !start_mul_q && !start_div_q
                   && !mul_pend_q && !div_busy && !mul_done && !div_done;

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            start_mul_q <= 1'b0;
            start_div_q <= 1'b0;
            mul_pend_q  <= 1'b0;
        end else begin
            start_mul_q <= issue && is_mul;
            start_div_q <= issue && is_div;
            if (issue && is_mul) begin
                mul_pend_q <= 1'b1;
            end else if (mul_done) begin
                mul_pend_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            op_a_q <= src1_i;
            op_b_q <= src2_i;
            sgn_q  <= is_mul ? (op_i != ex_pkg::MULHWU)
                             : (op_i == ex_pkg::DIVW || op_i == ex_pkg::MODW);
        end
    end

    ex_mul #(
        .MUL_STAGES(MUL_STAGES)
    ) u_mul (
        .clk      (clk),
        .reset_i  (reset_i),
        .flush_i  (flush_i),
        .start_i  (start_mul_q),
        .signed_i (sgn_q),
        .a_i      (op_a_q),
        .b_i      (op_b_q),
        .done_o   (mul_done),
        .product_o(product)
    );

    ex_div u_div (
        .clk        (clk),
        .reset_i    (reset_i),
        .flush_i    (flush_i),
        .start_i    (start_div_q),
        .signed_i   (sgn_q),
        .dividend_i (op_a_q),
        .divisor_i  (op_b_q),
        .busy_o     (div_busy),
        .done_o     (div_done),
        .quotient_o (quotient),
        .remainder_o(remainder)
    );

    always_comb begin
        case (op_i)
            ex_pkg::ADD:  alu_res = src1_i + src2_i;
            ex_pkg::SUB:  alu_res = src1_i - src2_i;
            ex_pkg::SLT:  alu_res = {31'b0, $signed(src1_i) < $signed(src2_i)};
            ex_pkg::SLTU: alu_res = {31'b0, src1_i < src2_i};
            ex_pkg::AND:  alu_res = src1_i & src2_i;
            ex_pkg::OR:   alu_res = src1_i | src2_i;
            ex_pkg::XOR:  alu_res = src1_i ^ src2_i;
            ex_pkg::NOR:  alu_res = ~(src1_i | src2_i);
            ex_pkg::SLL:  alu_res = src1_i << shamt;
            ex_pkg::SRL:  alu_res = src1_i >> shamt;
            ex_pkg::SRA:  alu_res = $signed(src1_i) >>> shamt;
            default:      alu_res = '0;
        endcase
    end

    always_comb begin
        case (cls)
            ex_pkg::CLS_ALU: result_o = alu_res;
            ex_pkg::CLS_MUL: result_o = (op_i == ex_pkg::MULW) ? product[31:0] : product[63:32];
            ex_pkg::CLS_DIV: begin
                if (op_i == ex_pkg::DIVW || op_i == ex_pkg::DIVWU) begin
                    result_o = quotient;
                end else begin
                    result_o = remainder;
                end
            end
            default:         result_o = '0;
        endcase
    end

    assign busy_o = (is_mul && !mul_done) || (is_div && !div_done); // drops in the done cycle

endmodule

//--- hw/ex_combine.sv
module ex_combine (
    input  logic                    valid_i,
    input  ex_pkg::alu_op_e         op_i,
    input  logic                    flush_i,
    input  logic                    mem_stall_i,
    input  logic                    rd_we_i,
    input  logic [4:0]              rd_addr_i,
    input  logic [ex_pkg::XLEN-1:0] arith_result_i,
    input  logic                    arith_busy_i,
    input  logic                    align_err_i,
    input  logic [3:0]              mem_be_i,
    input  logic [ex_pkg::XLEN-1:0] mem_wdata_i,
    input  logic                    mem_we_i,
    output logic                    stall_o,
    output logic                    valid_o,
    output logic                    rd_we_o,
    output logic [4:0]              rd_addr_o,
    output logic [ex_pkg::XLEN-1:0] rd_data_o,
    output logic                    exc_o,
    output logic [6:0]              exc_cause_o,
    output logic                    mem_req_o,
    output logic                    mem_we_o,
    output logic [3:0]              mem_be_o,
    output logic [ex_pkg::XLEN-1:0] mem_wdata_o
);

    logic live;
    logic is_mem;

    assign live   = valid_i && !flush_i; // flush kills the op outright
    assign is_mem = (ex_pkg::class_of(op_i) == ex_pkg::CLS_MEM);

    assign exc_o       = live && is_mem && align_err_i;
    assign exc_cause_o = exc_o ? lsu_pkg::ECODE_ALE : 7'd0;
    assign mem_req_o   = live && is_mem && !align_err_i;
    assign stall_o     = live && (arith_busy_i || (mem_req_o && mem_stall_i));
    assign valid_o     = live && !stall_o;

    // stores never write a register
    assign rd_we_o     = valid_o && rd_we_i && !exc_o && !(is_mem && mem_we_i);
    assign rd_addr_o   = rd_addr_i;
    assign rd_data_o   = is_mem ? '0 : arith_result_i; // load data merged later

    assign mem_we_o    = mem_req_o && mem_we_i;
    assign mem_be_o    = mem_req_o ? mem_be_i : 4'b0000;
    assign mem_wdata_o = mem_req_o ? mem_wdata_i : '0;

endmodule

//--- hw/ex_div.sv
module ex_div (
    input  logic        clk,
    input  logic        reset_i,
    input  logic        flush_i,
    input  logic        start_i,
    input  logic        signed_i,
    input  logic [31:0] dividend_i,
    input  logic [31:0] divisor_i,
    output logic        busy_o,
    output logic        done_o,
    output logic [31:0] quotient_o,
    output logic [31:0] remainder_o
);

    logic        busy_q;
    logic        done_q;
    logic [4:0]  cnt_q;
    logic [31:0] quot_q;
    logic [31:0] rem_q;
    logic [31:0] dvsr_q;
    logic [31:0] dvnd_q;
    logic        neg_quot_q;
    logic        neg_rem_q;
    logic        div0_q;
    logic        ovf_q;
    logic [31:0] a_mag;
    logic [31:0] b_mag;
    logic [32:0] shifted;
    logic [33:0] diff;
    logic        load;

    assign load    = start_i && !busy_q;
    assign a_mag   = (signed_i && dividend_i[31]) ? -dividend_i : dividend_i;
    assign b_mag   = (signed_i && divisor_i[31]) ? -divisor_i : divisor_i;
    assign shifted = {rem_q, quot_q[31]};
    assign diff    = {1'b0, shifted} - {2'b0, dvsr_q}; // msb set means restore

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            cnt_q  <= '0;
        end else begin
            done_q <= 1'b0;
            if (load) begin
                busy_q <= 1'b1;
                cnt_q  <= '0;
            end else if (busy_q) begin
                cnt_q <= cnt_q + 5'd1;
                if (cnt_q == 5'd31) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            quot_q     <= a_mag; // dividend bits shift out as quotient bits shift in
            rem_q      <= '0;
            dvsr_q     <= b_mag;
            dvnd_q     <= dividend_i;
            neg_quot_q <= signed_i && (dividend_i[31] ^ divisor_i[31]);
            neg_rem_q  <= signed_i && dividend_i[31];
            div0_q     <= (divisor_i == '0);
            ovf_q      <= signed_i && (dividend_i == 32'h8000_0000) && (divisor_i == '1);
        end else if (busy_q) begin
            if (!diff[33]) begin
                rem_q  <= diff[31:0];
                quot_q <= {quot_q[30:0], 1'b1};
            end else begin
                rem_q  <= shifted[31:0];
                quot_q <= {quot_q[30:0], 1'b0};
            end
        end
    end

    always_comb begin
        if (div0_q) begin
            quotient_o  = '1;
            remainder_o = dvnd_q;
        end else if (ovf_q) begin
            quotient_o  = 32'h8000_0000;
            remainder_o = '0;
        end else begin
            quotient_o  = neg_quot_q ? -quot_q : quot_q;
            remainder_o = neg_rem_q ? -rem_q : rem_q; // takes dividend sign
        end
    end

    assign busy_o = busy_q;
    assign done_o = done_q;

endmodule

//--- hw/ex_mul.sv
module ex_mul #(
    parameter int MUL_STAGES = 2
) (
    input  logic        clk,
    input  logic        reset_i,
    input  logic        flush_i,
    input  logic        start_i,
    input  logic        signed_i,
    input  logic [31:0] a_i,
    input  logic [31:0] b_i,
    output logic        done_o,
    output logic [63:0] product_o
);

    logic signed [32:0] a_ext;
    logic signed [32:0] b_ext;
    logic signed [65:0] prod_full;
    logic [MUL_STAGES-1:0] vld_q;
    logic [63:0] prod_q [MUL_STAGES];

    assign a_ext = {signed_i & a_i[31], a_i}; // zero-extend when unsigned
    assign b_ext = {signed_i & b_i[31], b_i};
    assign prod_full = a_ext * b_ext;

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            vld_q <= '0;
        end else begin
            vld_q[0] <= start_i;
            for (int i = 1; i < MUL_STAGES; i++) begin
                vld_q[i] <= vld_q[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        prod_q[0] <= prod_full[63:0];
        for (int i = 1; i < MUL_STAGES; i++) begin
            prod_q[i] <= prod_q[i-1];
        end
    end

    assign done_o    = vld_q[MUL_STAGES-1];
    assign product_o = prod_q[MUL_STAGES-1];

endmodule

//--- hw/ex_pkg.sv
package ex_pkg;

    parameter int XLEN = 32;

    typedef enum logic [4:0] {
        ADD,
        SUB,
        SLT,
        SLTU,
        AND,
        OR,
        XOR,
        NOR,
        SLL,
        SRL,
        SRA,
        MULW,
        MULHW,
        MULHWU,
        DIVW,
        DIVWU,
        MODW,
        MODWU,
        LDB,
        LDBU,
        LDH,
        LDHU,
        LDW,
        STB,
        STH,
        STW,
        NOP
    } alu_op_e;

    typedef enum logic [1:0] {
        CLS_ALU,
        CLS_MUL,
        CLS_DIV,
        CLS_MEM
    } op_class_e;

    function automatic op_class_e class_of(alu_op_e op);
        case (op)
            MULW, MULHW, MULHWU:                 return CLS_MUL;
            DIVW, DIVWU, MODW, MODWU:            return CLS_DIV;
            LDB, LDBU, LDH, LDHU, LDW,
            STB, STH, STW:                       return CLS_MEM;
            default:                             return CLS_ALU; // nop included
        endcase
    endfunction

endpackage

//--- hw/ex_stage.sv
module ex_stage #(
    parameter int MUL_STAGES = 2
) (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    flush_i,
    input  logic                    valid_i,
    input  ex_pkg::alu_op_e         op_i,
    input  logic [ex_pkg::XLEN-1:0] src1_i,
    input  logic [ex_pkg::XLEN-1:0] src2_i,
    input  logic [ex_pkg::XLEN-1:0] imm_i,
    input  logic                    rd_we_i,
    input  logic [4:0]              rd_addr_i,
    input  logic                    mem_stall_i,
    output logic                    stall_o,
    output logic                    valid_o,
    output logic                    rd_we_o,
    output logic [4:0]              rd_addr_o,
    output logic [ex_pkg::XLEN-1:0] rd_data_o,
    output logic                    exc_o,
    output logic [6:0]              exc_cause_o,
    output logic                    mem_req_o,
    output logic                    mem_we_o,
    output logic [ex_pkg::XLEN-1:0] mem_addr_o,
    output logic [3:0]              mem_be_o,
    output logic [ex_pkg::XLEN-1:0] mem_wdata_o
);

    logic [ex_pkg::XLEN-1:0] arith_result;
    logic                    arith_busy;
    logic [3:0]              mem_be;
    logic [ex_pkg::XLEN-1:0] mem_wdata;
    logic                    mem_we;
    logic                    align_err;

    ex_arith #(
        .MUL_STAGES(MUL_STAGES)
    ) u_arith (
        .clk     (clk),
        .reset_i (reset_i),
        .flush_i (flush_i),
        .valid_i (valid_i),
        .op_i    (op_i),
        .src1_i  (src1_i),
        .src2_i  (src2_i),
        .result_o(arith_result),
        .busy_o  (arith_busy)
    );

    ex_agu u_agu (
        .op_i       (op_i),
        .src1_i     (src1_i),
        .src2_i     (src2_i),
        .imm_i      (imm_i),
        .addr_o     (mem_addr_o), // address goes out ungated
        .be_o       (mem_be),
        .wdata_o    (mem_wdata),
        .we_o       (mem_we),
        .align_err_o(align_err)
    );

    ex_combine u_combine (
        .valid_i       (valid_i),
        .op_i          (op_i),
        .flush_i       (flush_i),
        .mem_stall_i   (mem_stall_i),
        .rd_we_i       (rd_we_i),
        .rd_addr_i     (rd_addr_i),
        .arith_result_i(arith_result),
        .arith_busy_i  (arith_busy),
        .align_err_i   (align_err),
        .mem_be_i      (mem_be),
        .mem_wdata_i   (mem_wdata),
        .mem_we_i      (mem_we),
        .stall_o       (stall_o),
        .valid_o       (valid_o),
        .rd_we_o       (rd_we_o),
        .rd_addr_o     (rd_addr_o),
        .rd_data_o     (rd_data_o),
        .exc_o         (exc_o),
        .exc_cause_o   (exc_cause_o),
        .mem_req_o     (mem_req_o),
        .mem_we_o      (mem_we_o),
        .mem_be_o      (mem_be_o),
        .mem_wdata_o   (mem_wdata_o)
    );

endmodule

//--- hw/lsu_pkg.sv
package lsu_pkg;

    typedef enum logic [1:0] {
        SZ_BYTE,
        SZ_HALF,
        SZ_WORD
    } mem_size_e;

    // address error cause
    parameter logic [6:0] ECODE_ALE = 7'd9;

    function automatic mem_size_e size_of(ex_pkg::alu_op_e op);
        case (op)
            ex_pkg::LDB, ex_pkg::LDBU, ex_pkg::STB: begin
                return SZ_BYTE;
            end
            ex_pkg::LDH, ex_pkg::LDHU, ex_pkg::STH: begin
                return SZ_HALF;
            end
            default: begin
                return SZ_WORD;
            end
        endcase
    endfunction

endpackage

//--- sources.f
hw/ex_pkg.sv
hw/lsu_pkg.sv
hw/ex_mul.sv
hw/ex_div.sv
hw/ex_arith.sv
hw/ex_agu.sv
hw/ex_combine.sv
hw/ex_stage.sv
verif/ex_stage_properties.sv
verif/ex_stage_tb.sv

//--- verif/ex_stage_properties.sv
module ex_stage_properties (
    input logic clk,
    input logic reset_i,
    input logic flush_i,
    input logic stall_o,
    input logic valid_o,
    input logic rd_we_o,
    input logic mem_req_o,
    input logic exc_o
);

    flush_no_stall: assert property (@(posedge clk) disable iff (reset_i) flush_i |-> !stall_o)
        else $error("stall_o high while flush_i is high");

    req_or_exc: assert property (@(posedge clk) disable iff (reset_i) !(mem_req_o && exc_o))
        else $error("mem_req_o and exc_o high together");

    we_needs_valid: assert property (@(posedge clk) disable iff (reset_i) rd_we_o |-> valid_o)
        else $error("rd_we_o high without valid_o");

    // first cycle out of reset
    idle_after_reset: assert property (@(posedge clk) $fell(reset_i) |-> !stall_o && !valid_o)
        else $error("stall_o or valid_o high right after reset");

endmodule

bind ex_stage ex_stage_properties u_props (
    .clk      (clk),
    .reset_i  (reset_i),
    .flush_i  (flush_i),
    .stall_o  (stall_o),
    .valid_o  (valid_o),
    .rd_we_o  (rd_we_o),
    .mem_req_o(mem_req_o),
    .exc_o    (exc_o)
);

//--- verif/ex_stage_tb.sv
module ex_stage_tb;

    localparam int MUL_STAGES = 2;

    logic            clk;
    logic            reset_i;
    logic            flush_i;
    logic            valid_i;
    ex_pkg::alu_op_e op_i;
    logic [31:0]     src1_i;
    logic [31:0]     src2_i;
    logic [31:0]     imm_i;
    logic            rd_we_i;
    logic [4:0]      rd_addr_i;
    logic            mem_stall_i;
    logic            stall_o;
    logic            valid_o;
    logic            rd_we_o;
    logic [4:0]      rd_addr_o;
    logic [31:0]     rd_data_o;
    logic            exc_o;
    logic [6:0]      exc_cause_o;
    logic            mem_req_o;
    logic            mem_we_o;
    logic [31:0]     mem_addr_o;
    logic [3:0]      mem_be_o;
    logic [31:0]     mem_wdata_o;
    logic [31:0]     rng_state;

    ex_stage #(.MUL_STAGES(MUL_STAGES)) uut (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift();
        logic [31:0] x;
        x = rng_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng_state = x;
        return x;
    endfunction

    task automatic check_equal(input string test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Fail %s %s expected %h actual %h", test, what, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "%s: wrong value on %s", test, what);
        end
    endtask

    task automatic next_sample();
        @(posedge clk);
        #3;
    endtask

    task automatic drive_op(input ex_pkg::alu_op_e op, input logic [31:0] a,
                            input logic [31:0] b, input logic [31:0] imm);
        @(posedge clk);
        #1;
        valid_i   = 1'b1;
        op_i      = op;
        src1_i    = a;
        src2_i    = b;
        imm_i     = imm;
        rd_we_i   = 1'b1;
        rd_addr_i = a[4:0] ^ b[9:5];
        #2; // outputs settled here
    endtask

    task automatic go_idle();
        @(posedge clk);
        #1;
        valid_i = 1'b0;
        op_i    = ex_pkg::NOP;
        rd_we_i = 1'b0;
    endtask

    task automatic wait_not_stalled(input string test, output int cycles);
        cycles = 0;
        while (stall_o) begin
            if (cycles == 100) begin
                $display("%s: stall_o did not drop within 100 cycles", test);
                $display("TEST FAILED");
                $fatal(1, "%s: stall timeout", test);
            end
            next_sample();
            cycles++;
        end
    endtask

    function automatic logic [31:0] alu_model(input ex_pkg::alu_op_e op, input logic [31:0] a,
                                              input logic [31:0] b);
        logic [63:0] ext;
        ext = {{32{a[31]}}, a} >> b[4:0]; // sign bits shift in from the top half
        case (op)
            ex_pkg::ADD:  return a + b;
            ex_pkg::SUB:  return a + ~b + 32'd1;
            ex_pkg::SLT:  return 32'((a[31] != b[31]) ? a[31] : (a < b));
            ex_pkg::SLTU: return 32'(a < b);
            ex_pkg::AND:  return a & b;
            ex_pkg::OR:   return a | b;
            ex_pkg::XOR:  return a ^ b;
            ex_pkg::NOR:  return ~(a | b);
            ex_pkg::SLL:  return a << b[4:0];
            ex_pkg::SRL:  return a >> b[4:0];
            ex_pkg::SRA:  return ext[31:0];
            default:      return 32'd0;
        endcase
    endfunction

    function automatic logic [31:0] long_model(input ex_pkg::alu_op_e op, input logic [31:0] a,
                                               input logic [31:0] b);
        logic   sgn;
        longint na;
        longint nb;
        longint r;
        sgn = (op == ex_pkg::MULW) || (op == ex_pkg::MULHW) || (op == ex_pkg::DIVW)
              || (op == ex_pkg::MODW);
        na  = sgn ? longint'($signed(a)) : longint'({32'd0, a});
        nb  = sgn ? longint'($signed(b)) : longint'({32'd0, b});
        case (op)
            ex_pkg::MULW:                  r = na * nb;
            ex_pkg::MULHW, ex_pkg::MULHWU: r = (na * nb) >>> 32; // high word
            ex_pkg::DIVW, ex_pkg::DIVWU:   r = (b == 32'd0) ? -64'sd1 : na / nb;
            default:                       r = (b == 32'd0) ? na : na % nb;
        endcase
        return r[31:0]; // overflow quotient wraps to 8000_0000
    endfunction

    task automatic run_long_op(input string test, input ex_pkg::alu_op_e op,
                               input logic [31:0] a, input logic [31:0] b);
        int          cycles;
        logic [31:0] latency;
        latency = (ex_pkg::class_of(op) == ex_pkg::CLS_MUL) ? 32'(MUL_STAGES + 1) : 32'd34;
        drive_op(op, a, b, 32'd0);
        check_equal(test, "stall_o at start", 32'd1, 32'(stall_o));
        check_equal(test, "valid_o at start", 32'd0, 32'(valid_o));
        wait_not_stalled(test, cycles);
        check_equal(test, $sformatf("cycles to complete %s", op.name()), latency, 32'(cycles));
        check_equal(test, "valid_o", 32'd1, 32'(valid_o));
        check_equal(test, "rd_we_o", 32'd1, 32'(rd_we_o));
        check_equal(test, $sformatf("rd_data_o of %s %h %h", op.name(), a, b),
                    long_model(op, a, b), rd_data_o);
    endtask

    task automatic test_alu();
        ex_pkg::alu_op_e op;
        logic [31:0]     a;
        logic [31:0]     b;
        for (int i = 0; i < 200; i++) begin
            op = ex_pkg::alu_op_e'(5'(xorshift() % 32'd11)); // ADD up to SRA
            a  = xorshift();
            b  = (i % 10 == 0) ? a : xorshift();
            drive_op(op, a, b, xorshift());
            check_equal("test_alu", "stall_o", 32'd0, 32'(stall_o));
            check_equal("test_alu", "valid_o", 32'd1, 32'(valid_o));
            check_equal("test_alu", "rd_we_o", 32'd1, 32'(rd_we_o));
            check_equal("test_alu", "mem_req_o", 32'd0, 32'(mem_req_o));
            check_equal("test_alu", "rd_addr_o", 32'(rd_addr_i), 32'(rd_addr_o));
            check_equal("test_alu", $sformatf("rd_data_o of %s", op.name()),
                        alu_model(op, a, b), rd_data_o);
        end
        go_idle();
    endtask

    task automatic test_mul();
        ex_pkg::alu_op_e ops [3] = '{ex_pkg::MULW, ex_pkg::MULHW, ex_pkg::MULHWU};
        logic [31:0] edge_a [4] = '{32'h8000_0000, 32'hffff_ffff, 32'h7fff_ffff, 32'h0};
        logic [31:0] edge_b [4] = '{32'h8000_0000, 32'hffff_ffff, 32'hffff_ffff, 32'h1234_5678};
        for (int i = 0; i < 30; i++) begin
            if (i < 12) begin
                run_long_op("test_mul", ops[i % 3], edge_a[i / 3], edge_b[i / 3]);
            end else begin
                run_long_op("test_mul", ops[i % 3], xorshift(), xorshift());
            end
        end
        go_idle();
    endtask

    task automatic test_div();
        ex_pkg::alu_op_e ops [4] = '{ex_pkg::DIVW, ex_pkg::DIVWU, ex_pkg::MODW, ex_pkg::MODWU};
        logic [31:0] edge_a [4] = '{32'h8000_0000, 32'h1234_5678, 32'h8000_0000, 32'hffff_fff9};
        logic [31:0] edge_b [4] = '{32'hffff_ffff, 32'h0, 32'h0, 32'h2};
        for (int i = 0; i < 32; i++) begin
            if (i < 16) begin
                run_long_op("test_div", ops[i % 4], edge_a[i / 4], edge_b[i / 4]);
            end else begin
                run_long_op("test_div", ops[i % 4], xorshift(),
                            xorshift() >> (xorshift() % 32'd32));
            end
        end
        go_idle();
    endtask

    task automatic test_mem();
        ex_pkg::alu_op_e ops [8] = '{ex_pkg::LDB, ex_pkg::LDBU, ex_pkg::LDH, ex_pkg::LDHU,
                                     ex_pkg::LDW, ex_pkg::STB, ex_pkg::STH, ex_pkg::STW};
        string       name;
        logic [31:0] data;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  be;
        int          bytes;
        int          first;
        logic        store;
        logic        mis;
        for (int i = 0; i < 8; i++) begin
            for (int off = 0; off < 4; off++) begin
                name  = $sformatf("test_mem %s offset %0d", ops[i].name(), off);
                store = (i >= 5);
                bytes = (i < 2 || i == 5) ? 1 : ((i < 4 || i == 6) ? 2 : 4);
                first = (bytes == 1) ? off : ((bytes == 2) ? (off & 2) : 0);
                mis   = (off % bytes) != 0;
                data  = xorshift();
                addr  = (xorshift() & 32'hffff_fffc) + 32'(off);
                be    = 4'(((1 << bytes) - 1) << first);
                wdata = store ? (data & (32'hffff_ffff >> (32 - 8 * bytes))) << (8 * first)
                              : 32'd0;
                if (store) begin
                    drive_op(ops[i], addr - 32'(off) - 32'h40, data, 32'h40 + 32'(off));
                end else begin
                    drive_op(ops[i], addr - 32'(off) - 32'h40, 32'h40 + 32'(off), data);
                end
                check_equal(name, "mem_addr_o", addr, mem_addr_o);
                check_equal(name, "exc_o", 32'(mis), 32'(exc_o));
                check_equal(name, "exc_cause_o", mis ? 32'd9 : 32'd0, 32'(exc_cause_o));
                check_equal(name, "mem_req_o", 32'(!mis), 32'(mem_req_o));
                check_equal(name, "mem_we_o", 32'(store && !mis), 32'(mem_we_o));
                check_equal(name, "mem_be_o", mis ? 32'd0 : 32'(be), 32'(mem_be_o));
                check_equal(name, "mem_wdata_o", mis ? 32'd0 : wdata, mem_wdata_o);
                check_equal(name, "rd_we_o", 32'(!store && !mis), 32'(rd_we_o));
                check_equal(name, "valid_o", 32'd1, 32'(valid_o));
                check_equal(name, "rd_data_o", 32'd0, rd_data_o);
            end
        end
        go_idle();
    endtask

    task automatic test_stall_flush();
        logic [31:0] addr;
        logic [31:0] data;
        addr = xorshift() & 32'hffff_fffc;
        data = xorshift();
        @(posedge clk);
        #1;
        mem_stall_i = 1'b1;
        drive_op(ex_pkg::STW, addr, data, 32'd0);
        for (int i = 0; i < 4; i++) begin
            if (i > 0) begin
                next_sample();
            end
            check_equal("test_stall_flush", "valid_o while blocked", 32'd0, 32'(valid_o));
            check_equal("test_stall_flush", "stall_o while blocked", 32'd1, 32'(stall_o));
            check_equal("test_stall_flush", "mem_req_o while blocked", 32'd1, 32'(mem_req_o));
            check_equal("test_stall_flush", "mem_addr_o while blocked", addr, mem_addr_o);
            check_equal("test_stall_flush", "mem_be_o while blocked", 32'hf, 32'(mem_be_o));
            check_equal("test_stall_flush", "mem_wdata_o while blocked", data, mem_wdata_o);
        end
        @(posedge clk);
        #1;
        mem_stall_i = 1'b0;
        #2;
        check_equal("test_stall_flush", "stall_o after release", 32'd0, 32'(stall_o));
        check_equal("test_stall_flush", "valid_o after release", 32'd1, 32'(valid_o));
        check_equal("test_stall_flush", "mem_we_o after release", 32'd1, 32'(mem_we_o));
        check_equal("test_stall_flush", "rd_we_o of store", 32'd0, 32'(rd_we_o));

        drive_op(ex_pkg::DIVW, data, 32'd7, 32'd0);
        for (int i = 0; i < 5; i++) begin
            if (i > 0) begin
                next_sample();
            end
            check_equal("test_stall_flush", "stall_o during divide", 32'd1, 32'(stall_o));
        end
        @(posedge clk);
        #1;
        flush_i = 1'b1; // divide still running
        #2;
        check_equal("test_stall_flush", "stall_o in flush", 32'd0, 32'(stall_o));
        check_equal("test_stall_flush", "valid_o in flush", 32'd0, 32'(valid_o));
        check_equal("test_stall_flush", "rd_we_o in flush", 32'd0, 32'(rd_we_o));
        @(posedge clk);
        #1;
        flush_i = 1'b0;
        op_i    = ex_pkg::ADD;
        src1_i  = data;
        src2_i  = addr;
        #2;
        check_equal("test_stall_flush", "stall_o after flush", 32'd0, 32'(stall_o));
        check_equal("test_stall_flush", "valid_o after flush", 32'd1, 32'(valid_o));
        check_equal("test_stall_flush", "rd_data_o after flush", data + addr, rd_data_o);
        go_idle();
    endtask

    initial begin
        clk         = 1'b0;
        reset_i     = 1'b1;
        flush_i     = 1'b0;
        valid_i     = 1'b0;
        op_i        = ex_pkg::NOP;
        src1_i      = 32'd0;
        src2_i      = 32'd0;
        imm_i       = 32'd0;
        rd_we_i     = 1'b0;
        rd_addr_i   = 5'd0;
        mem_stall_i = 1'b0;
        rng_state   = 32'h1ee6_b645;
        repeat (2) @(posedge clk);
        #1;
        reset_i = 1'b0;
        #2;
        check_equal("reset", "stall_o", 32'd0, 32'(stall_o));
        check_equal("reset", "valid_o", 32'd0, 32'(valid_o));
        check_equal("reset", "mem_req_o", 32'd0, 32'(mem_req_o));
        check_equal("reset", "rd_we_o", 32'd0, 32'(rd_we_o));
        test_alu();
        test_mul();
        test_div();
        test_mem();
        test_stall_flush();
        $display("TEST PASSED");
        $finish;
    end

endmodule
